// ==== verilog/fpc_pkg.sv ====
// Operation codes, widths, numeric limits, queue depth and the request and result structs.
package fpc_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int OP_W      = 2;
  localparam int TAG_W     = 4;
  localparam int OPERAND_W = 32;
  localparam int RES_W     = 64;
  localparam int FLAG_W    = 2;
  localparam int EXP_W     = 9;    // Unbiased exponent, signed.
  localparam int MANT_W    = 24;   // Mantissa including the hidden bit.

  localparam int FIFO_DEPTH = 4;   // Result queue entries and issue credits.

  ////////////////////
  // Operation codes
  ////////////////////
  localparam logic [OP_W-1:0] OP_CVT32    = 2'd0;
  localparam logic [OP_W-1:0] OP_CVT64    = 2'd1;
  localparam logic [OP_W-1:0] OP_VERBATIM = 2'd2;  // Code 3 decodes the same way.

  localparam int FLAG_INVALID = 1;
  localparam int FLAG_INEXACT = 0;

  // Exponent constants in the unbiased domain.
  localparam logic signed [EXP_W-1:0] EXP_BIAS    = 9'sd127;
  localparam logic signed [EXP_W-1:0] EXP_SPECIAL = 9'sd128;  // Infinity or NaN.
  localparam logic signed [EXP_W-1:0] LIM_INT32   = 9'sd31;
  localparam logic signed [EXP_W-1:0] LIM_INT64   = 9'sd63;

  localparam logic [RES_W-1:0] INT32_MAX = 64'h0000_0000_7fff_ffff;
  localparam logic [RES_W-1:0] INT32_MIN = 64'hffff_ffff_8000_0000;
  localparam logic [RES_W-1:0] INT64_MAX = 64'h7fff_ffff_ffff_ffff;
  localparam logic [RES_W-1:0] INT64_MIN = 64'h8000_0000_0000_0000;

  typedef struct packed {
    logic [TAG_W-1:0]         tag;
    logic [OPERAND_W-1:0]     operand;
    logic                     is_32b;
    logic                     verbatim;
    logic                     sign;
    logic signed [EXP_W-1:0]  exp;
    logic [MANT_W-1:0]        mant;
  } cvt_req_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [RES_W-1:0]  result;
    logic [FLAG_W-1:0] flags;
  } cvt_result_t;

endpackage

// ==== verilog/fpc_if.sv ====
// Interfaces cvt_req_if (issue to converter) and cvt_res_if (converter to result queue).
`timescale 1ns/1ps

////////////////////
// Decoded request
////////////////////
interface cvt_req_if;

  logic               valid;  // One decoded operation this cycle.
  fpc_pkg::cvt_req_t  data;   // Tag, operand and precomputed fields.

  // No ready here; issue credits guarantee the queue has room.
  modport src (
    output valid,
    output data
  );

  modport dst (
    input  valid,
    input  data
  );

endinterface

////////////////////
// Converter result
////////////////////
interface cvt_res_if;

  logic                  valid;  // Result written into the queue this cycle.
  fpc_pkg::cvt_result_t  data;   // Tag, 64-bit result and flags.

  modport src (
    output valid,
    output data
  );

  modport dst (
    input  valid,
    input  data
  );

endinterface

// ==== verilog/fpc_issue.sv ====
// Issue stage: operation accept, decode into converter controls and queue credit counter.
`timescale 1ns/1ps

module fpc_issue (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [fpc_pkg::OP_W-1:0]        in_op,
  input  logic [fpc_pkg::TAG_W-1:0]       in_tag,
  input  logic [fpc_pkg::OPERAND_W-1:0]   in_operand,
  input  logic                            pop,
  cvt_req_if.src                          req
);

  localparam int CRED_W = $clog2(fpc_pkg::FIFO_DEPTH + 1);

  logic [CRED_W-1:0]  credits;
  logic               accept;
  fpc_pkg::cvt_req_t  dec;
  logic [7:0]         raw_exp;

  assign in_ready = (credits != '0);        // Room left in the result queue.
  assign accept   = in_valid && in_ready;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    raw_exp      = in_operand[30:23];
    dec.tag      = in_tag;
    dec.operand  = in_operand;
    dec.sign     = in_operand[31];
    dec.exp      = $signed({1'b0, raw_exp}) - fpc_pkg::EXP_BIAS;
    dec.mant     = {(raw_exp != 8'd0), in_operand[22:0]};  // Denormals get no hidden bit.
    case (in_op)
      fpc_pkg::OP_CVT32: begin
        dec.is_32b   = 1'b1;
        dec.verbatim = 1'b0;
      end
      fpc_pkg::OP_CVT64: begin
        dec.is_32b   = 1'b0;
        dec.verbatim = 1'b0;
      end
      default: begin                        // Verbatim and the reserved code.
        dec.is_32b   = 1'b0;
        dec.verbatim = 1'b1;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req.valid <= 1'b0;
      credits   <= CRED_W'(fpc_pkg::FIFO_DEPTH);
    end else begin
      req.valid <= accept;
      case ({accept, pop})
        2'b10:   credits <= credits - 1'b1;  // Spent on an accepted operation.
        2'b01:   credits <= credits + 1'b1;  // Returned by a retired result.
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.data <= dec;
    end
  end

endmodule

// ==== verilog/fpc_f2i_cvt.sv ====
// Registered float32 to int32/int64 converter with truncation, saturation and exception flags.
`timescale 1ns/1ps

module fpc_f2i_cvt (
  input  logic    clk,
  input  logic    rst_n,
  cvt_req_if.dst  req,
  cvt_res_if.src  res
);

  // Mantissa shifted left by up to 63 places keeps all fraction bits below the point.
  localparam int SHIFT_W = fpc_pkg::MANT_W + 63;

  logic signed [fpc_pkg::EXP_W-1:0]  lim;
  logic [fpc_pkg::RES_W-1:0]         max_pos;
  logic [fpc_pkg::RES_W-1:0]         min_neg;
  logic                              is_nan;
  logic                              is_min_exact;
  logic [SHIFT_W-1:0]                shifted;
  logic [fpc_pkg::RES_W-1:0]         magnitude;
  logic [fpc_pkg::MANT_W-2:0]        frac;
  logic [fpc_pkg::RES_W-1:0]         result;
  logic [fpc_pkg::FLAG_W-1:0]        flags;

  ////////////////////
  // Conversion
  ////////////////////
  always_comb begin
    lim     = req.data.is_32b ? fpc_pkg::LIM_INT32 : fpc_pkg::LIM_INT64;
    max_pos = req.data.is_32b ? fpc_pkg::INT32_MAX : fpc_pkg::INT64_MAX;
    min_neg = req.data.is_32b ? fpc_pkg::INT32_MIN : fpc_pkg::INT64_MIN;

    is_nan       = (req.data.exp == fpc_pkg::EXP_SPECIAL) && (req.data.mant[22:0] != '0);
    // Exactly -2^L is representable and converts without a flag.
    is_min_exact = req.data.sign && (req.data.exp == lim) && (req.data.mant[22:0] == '0);

    shifted   = SHIFT_W'(req.data.mant) << req.data.exp[5:0];
    magnitude = shifted[SHIFT_W-1 -: fpc_pkg::RES_W];  // Integer part.
    frac      = shifted[fpc_pkg::MANT_W-2:0];          // Bits dropped by truncation.

    result = '0;
    flags  = '0;
    if (req.data.verbatim) begin
      result = {{(fpc_pkg::RES_W - fpc_pkg::OPERAND_W){1'b0}}, req.data.operand};
    end else if (is_nan) begin
      result                      = max_pos;
      flags[fpc_pkg::FLAG_INVALID] = 1'b1;
    end else if ((req.data.exp >= lim) && !is_min_exact) begin
      result                      = req.data.sign ? min_neg : max_pos;  // Includes infinity.
      flags[fpc_pkg::FLAG_INVALID] = 1'b1;
    end else if (req.data.exp < 0) begin
      flags[fpc_pkg::FLAG_INEXACT] = (req.data.mant != '0);  // Plain zero stays exact.
    end else begin
      // Negation in 64 bits also sign-extends the int32 results.
      result                      = req.data.sign ? -magnitude : magnitude;
      flags[fpc_pkg::FLAG_INEXACT] = (frac != '0);
    end
  end

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= req.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      res.data.tag    <= req.data.tag;
      res.data.result <= result;
      res.data.flags  <= flags;
    end
  end

endmodule

// ==== verilog/fpc_result_fifo.sv ====
// In-order result queue: circular buffer with read and write pointers and an entry count.
`timescale 1ns/1ps

module fpc_result_fifo #(
  parameter int DEPTH = fpc_pkg::FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  cvt_res_if.dst                wr,
  output logic                  head_valid,
  output fpc_pkg::cvt_result_t  head,
  input  logic                  pop
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fpc_pkg::cvt_result_t  mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  rd_en;

  // Pointers wrap explicitly so any depth works.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];            // Visible one cycle after the write.
  assign rd_en      = pop && head_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr.valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr.valid, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage. The issue credits keep writes from landing on a full queue.
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr_ptr] <= wr.data;
    end
  end

endmodule

// ==== verilog/fpc_retire.sv ====
// Retire stage: output stream from the queue head, pop generation and sticky exception flags.
`timescale 1ns/1ps

module fpc_retire (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          head_valid,
  input  fpc_pkg::cvt_result_t          head,
  output logic                          pop,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [fpc_pkg::TAG_W-1:0]     out_tag,
  output logic [fpc_pkg::RES_W-1:0]     out_result,
  output logic [fpc_pkg::FLAG_W-1:0]    out_flags,
  input  logic                          sticky_clr,
  output logic [fpc_pkg::FLAG_W-1:0]    sticky_flags
);

  ////////////////////
  // Output stream
  ////////////////////
  assign out_valid  = head_valid;            // Head holds until it is popped.
  assign out_tag    = head.tag;
  assign out_result = head.result;
  assign out_flags  = head.flags;
  assign pop        = head_valid && out_ready;  // Also the credit return to issue.

  ////////////////////
  // Sticky flags
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_flags <= '0;
    end else if (sticky_clr) begin
      sticky_flags <= '0;                    // Clear wins over a same-cycle retire.
    end else if (pop) begin
      sticky_flags <= sticky_flags | head.flags;
    end
  end

endmodule

// ==== verilog/fpc_cluster_top.sv ====
// Top level of the float to integer conversion slice: issue, converter, result queue, retire.
`timescale 1ns/1ps

module fpc_cluster_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [fpc_pkg::OP_W-1:0]        in_op,
  input  logic [fpc_pkg::TAG_W-1:0]       in_tag,
  input  logic [fpc_pkg::OPERAND_W-1:0]   in_operand,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [fpc_pkg::TAG_W-1:0]       out_tag,
  output logic [fpc_pkg::RES_W-1:0]       out_result,
  output logic [fpc_pkg::FLAG_W-1:0]      out_flags,
  input  logic                            sticky_clr,
  output logic [fpc_pkg::FLAG_W-1:0]      sticky_flags
);

  logic                  head_valid;
  fpc_pkg::cvt_result_t  head;
  logic                  pop;                // Queue pop and issue credit return.

  cvt_req_if req_if ();
  cvt_res_if res_if ();

  fpc_issue u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_tag     (in_tag),
    .in_operand (in_operand),
    .pop        (pop),
    .req        (req_if.src)
  );

  fpc_f2i_cvt u_cvt (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_if.dst),
    .res   (res_if.src)
  );

  fpc_result_fifo #(
    .DEPTH (fpc_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (res_if.dst),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop)
  );

  fpc_retire u_retire (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_valid   (head_valid),
    .head         (head),
    .pop          (pop),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_tag      (out_tag),
    .out_result   (out_result),
    .out_flags    (out_flags),
    .sticky_clr   (sticky_clr),
    .sticky_flags (sticky_flags)
  );

endmodule

// ==== tb/fpc_sva.sv ====
// Stream protocol assertions for the conversion slice, bound to its top level.
`timescale 1ns/1ps

module fpc_sva (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            in_valid,
  input logic                            in_ready,
  input logic [fpc_pkg::OP_W-1:0]        in_op,
  input logic [fpc_pkg::TAG_W-1:0]       in_tag,
  input logic [fpc_pkg::OPERAND_W-1:0]   in_operand,
  input logic                            out_valid,
  input logic                            out_ready,
  input logic [fpc_pkg::TAG_W-1:0]       out_tag,
  input logic [fpc_pkg::RES_W-1:0]       out_result,
  input logic [fpc_pkg::FLAG_W-1:0]      out_flags
);

  int err_cnt = 0;  // Number of failed assertions.

  // A stalled result keeps its valid and its fields until it transfers.
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable({out_tag, out_result, out_flags}))
    else begin
      err_cnt++;
      $error("Output stream changed while stalled.");
    end

  assert property (@(posedge clk) $rose(rst_n) |-> in_ready && !out_valid)
    else begin
      err_cnt++;
      $error("Wrong stream state after reset.");
    end

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown({in_ready, out_valid}))
    else begin
      err_cnt++;
      $error("Stream handshake signal is unknown.");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready |-> !$isunknown({in_op, in_tag, in_operand}))
    else begin
      err_cnt++;
      $error("Input transfer carries an unknown value.");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |-> !$isunknown({out_tag, out_result, out_flags}))
    else begin
      err_cnt++;
      $error("Output transfer carries an unknown value.");
    end

endmodule

bind fpc_cluster_top fpc_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .in_op      (in_op),
  .in_tag     (in_tag),
  .in_operand (in_operand),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_tag    (out_tag),
  .out_result (out_result),
  .out_flags  (out_flags)
);

// ==== tb/fpc_tb.sv ====
// Testbench for the conversion slice with its stimulus table, clock, reset, driver, checker and watchdog.
`timescale 1ns/1ps

module fpc_tb;

  localparam int NUM_TESTS = 16;
  localparam int BP_CYCLES = 20;                      // Cycles with out_ready held low.
  localparam int WATCHDOG  = NUM_TESTS * 40 + 50;
  localparam logic [1:0] OP32 = fpc_pkg::OP_CVT32;
  localparam logic [1:0] OP64 = fpc_pkg::OP_CVT64;
  localparam logic [1:0] OPVB = fpc_pkg::OP_VERBATIM;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic [1:0]  in_op;
  logic [3:0]  in_tag;
  logic [31:0] in_operand;
  logic        out_valid;
  logic        out_ready;
  logic [3:0]  out_tag;
  logic [63:0] out_result;
  logic [1:0]  out_flags;
  logic        sticky_clr;
  logic [1:0]  sticky_flags;

  string       names [NUM_TESTS];
  logic [1:0]  ops [NUM_TESTS];
  logic [31:0] operands [NUM_TESTS];
  logic [63:0] exp_result [NUM_TESTS];
  logic [1:0]  exp_flags [NUM_TESTS];
  int          arrivals [NUM_TESTS];
  int          exp_q [$];                             // Table indices in issue order.
  int          pass_cnt;
  int          fail_cnt;
  bit          hold_low;
  int          seed_val;

  fpc_cluster_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_op        (in_op),
    .in_tag       (in_tag),
    .in_operand   (in_operand),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_tag      (out_tag),
    .out_result   (out_result),
    .out_flags    (out_flags),
    .sticky_clr   (sticky_clr),
    .sticky_flags (sticky_flags)
  );

  always #10 clk = ~clk;                              // 20 ns period.

  task automatic add_entry(input int idx, input string name, input logic [1:0] op,
                           input logic [31:0] operand, input logic [63:0] result,
                           input logic [1:0] flags);
    names[idx]      = name;
    ops[idx]        = op;
    operands[idx]   = operand;
    exp_result[idx] = result;
    exp_flags[idx]  = flags;
    arrivals[idx]   = 0;
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic load_table();
    add_entry(0,  "cvt32_pos3",     OP32,  32'h40400000, 64'h0000000000000003, 2'b00);
    add_entry(1,  "cvt32_neg7p75",  OP32,  32'hC0F80000, 64'hFFFFFFFFFFFFFFF9, 2'b01);
    add_entry(2,  "cvt64_2pow40",   OP64,  32'h53800000, 64'h0000010000000000, 2'b00);
    add_entry(3,  "cvt32_sat_3e9",  OP32,  32'h4F32D05E, 64'h000000007FFFFFFF, 2'b10);
    add_entry(4,  "cvt32_neg_inf",  OP32,  32'hFF800000, 64'hFFFFFFFF80000000, 2'b10);
    add_entry(5,  "cvt32_nan",      OP32,  32'h7FC00000, 64'h000000007FFFFFFF, 2'b10);
    add_entry(6,  "cvt32_min",      OP32,  32'hCF000000, 64'hFFFFFFFF80000000, 2'b00);
    add_entry(7,  "cvt32_half",     OP32,  32'h3F000000, 64'h0000000000000000, 2'b01);
    add_entry(8,  "cvt32_pos_zero", OP32,  32'h00000000, 64'h0000000000000000, 2'b00);
    add_entry(9,  "verbatim",       OPVB,  32'hDEADBEEF, 64'h00000000DEADBEEF, 2'b00);
    add_entry(10, "cvt64_neg1p5",   OP64,  32'hBFC00000, 64'hFFFFFFFFFFFFFFFF, 2'b01);
    add_entry(11, "cvt64_sat_2p63", OP64,  32'h5F000000, 64'h7FFFFFFFFFFFFFFF, 2'b10);
    add_entry(12, "cvt64_min",      OP64,  32'hDF000000, 64'h8000000000000000, 2'b00);
    add_entry(13, "reserved_op",    2'd3,  32'h3F800000, 64'h000000003F800000, 2'b00);
    add_entry(14, "cvt32_denorm",   OP32,  32'h00000001, 64'h0000000000000000, 2'b01);
    add_entry(15, "cvt64_3e9",      OP64,  32'h4F32D05E, 64'h00000000B2D05E00, 2'b00);
  endtask

  // Holds one entry on the input stream until it transfers.
  task automatic issue_entry(input int idx);
    bit fire;
    in_valid   = 1'b1;
    in_op      = ops[idx];
    in_tag     = 4'(idx % 16);
    in_operand = operands[idx];
    fire       = in_ready;
    while (!fire) begin
      @(negedge clk);
      fire = in_ready;
    end
    exp_q.push_back(idx);
    @(posedge clk);
  endtask

  task automatic check_result();
    int         idx;
    logic [3:0] exp_tag;
    assert (exp_q.size() != 0) else begin
      fail_cnt++;
      $display("ERROR: result with tag %0d arrived while no operation was outstanding", out_tag);
    end
    if (exp_q.size() != 0) begin
      idx     = exp_q.pop_front();
      exp_tag = 4'(idx % 16);
      arrivals[out_tag]++;                            // Counted by the tag that came back.
      assert ((out_tag == exp_tag) && (out_result == exp_result[idx])
              && (out_flags == exp_flags[idx])) begin
        pass_cnt++;
        $display("ok %s tag=%0d result=%h flags=%b", names[idx], out_tag, out_result, out_flags);
      end else begin
        fail_cnt++;
        $display(
          "MISMATCH %s expected tag=%0d result=%h flags=%b actual tag=%0d result=%h flags=%b",
          names[idx], exp_tag, exp_result[idx], exp_flags[idx],
          out_tag, out_result, out_flags);
      end
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Random out_ready and the result checks both run on the falling edge.
  always @(negedge clk) begin
    if (!rst_n || hold_low) begin
      out_ready = 1'b0;
    end else begin
      out_ready = (($urandom % 4) != 0);               // Ready about three cycles in four.
    end
    if (out_valid && out_ready) begin
      check_result();
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int         dup_errs;
    logic [1:0] all_flags;
    int         accepted;
    int         bp_idx;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_op      = '0;
    in_tag     = '0;
    in_operand = '0;
    out_ready  = 1'b0;
    sticky_clr = 1'b0;
    hold_low   = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    seed_val   = $urandom(32'h4a5);
    load_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_TESTS; i++) begin
      @(negedge clk);
      if (($urandom % 3) == 0) begin
        in_valid = 1'b0;                               // Idle gap before this entry.
        @(negedge clk);
      end
      issue_entry(i);
    end
    @(negedge clk);
    in_valid = 1'b0;
    wait_drained();

    dup_errs  = 0;
    all_flags = 2'b00;
    for (int i = 0; i < NUM_TESTS; i++) begin
      dup_errs += (arrivals[i] != 1);
      all_flags |= exp_flags[i];
    end
    assert ((dup_errs == 0) && !out_valid) begin
      pass_cnt++;
      $display("ok every table entry retired exactly once");
    end else begin
      fail_cnt++;
      $display("ERROR: %0d table entries were lost or retired more than once", dup_errs);
    end
    assert (sticky_flags == all_flags) begin
      pass_cnt++;
      $display("ok sticky flags %b", sticky_flags);
    end else begin
      fail_cnt++;
      $display("MISMATCH sticky_or expected %b actual %b", all_flags, sticky_flags);
    end
    sticky_clr = 1'b1;
    @(negedge clk);
    sticky_clr = 1'b0;
    assert (sticky_flags == 2'b00) begin
      pass_cnt++;
      $display("ok sticky flags cleared");
    end else begin
      fail_cnt++;
      $display("MISMATCH sticky_clear expected 00 actual %b", sticky_flags);
    end

    // The queue and the credits fill up under back-pressure, and then everything drains.
    @(posedge clk);
    hold_low = 1'b1;
    accepted = 0;
    bp_idx   = 0;
    repeat (BP_CYCLES) begin
      @(negedge clk);
      in_valid   = 1'b1;
      in_op      = ops[bp_idx];
      in_tag     = 4'(bp_idx % 16);
      in_operand = operands[bp_idx];
      if (in_ready) begin
        exp_q.push_back(bp_idx);
        accepted++;
        bp_idx++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    assert ((accepted == fpc_pkg::FIFO_DEPTH) && !in_ready) begin
      pass_cnt++;
      $display("ok input stalled after %0d operations", accepted);
    end else begin
      fail_cnt++;
      $display("MISMATCH backpressure expected %0d accepted actual %0d (in_ready=%b)",
               fpc_pkg::FIFO_DEPTH, accepted, in_ready);
    end
    @(posedge clk);
    hold_low = 1'b0;
    wait_drained();
    assert (in_ready) begin
      pass_cnt++;
      $display("ok input ready again after the queue drained");
    end else begin
      fail_cnt++;
      $display("ERROR: in_ready stayed low after all results were retired");
    end

    assert (UUT.u_sva.err_cnt == 0) else begin
      fail_cnt += UUT.u_sva.err_cnt;
      $display("ERROR: %0d stream protocol assertions failed", UUT.u_sva.err_cnt);
    end

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/fpc_pkg.sv
verilog/fpc_if.sv
verilog/fpc_issue.sv
verilog/fpc_f2i_cvt.sv
verilog/fpc_result_fifo.sv
verilog/fpc_retire.sv
verilog/fpc_cluster_top.sv
tb/fpc_sva.sv
tb/fpc_tb.sv
